/* Bender.yml */
package:
  name: rv_core

sources:
  - design/rv_core_pkg.sv
  - design/dmem_req_if.sv
  - design/rv_decoder.sv
  - design/rv_regfile.sv
  - design/rv_alu.sv
  - design/rv_load_store.sv
  - design/rv_core.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/rv_core_assertions.sv
      - tests/rv_core_tb.sv

/* design/dmem_req_if.sv */
// ======================================
// Data memory request bundle
// One access from sequencer to load/store unit
// ======================================
`timescale 1ns/1ps

interface dmem_req_if;
   import rv_core_pkg::*;

   logic            valid;
   logic            write;
   logic [xlen-1:0] addr;
   logic [xlen-1:0] store_data;
   mem_size_e       size;
   logic            is_unsigned;
   // Extended read data, one cycle after valid
   logic [xlen-1:0] load_data;

   modport requester (
      output valid, write, addr, store_data, size, is_unsigned,
      input  load_data
   );

   modport unit (
      input  valid, write, addr, store_data, size, is_unsigned,
      output load_data
   );

endinterface

/* design/rv_alu.sv */
// ======================================
// Integer ALU with branch compare
// ======================================
`timescale 1ns/1ps

module rv_alu (
   input  rv_core_pkg::alu_op_e         op,
   input  logic [rv_core_pkg::xlen-1:0] a,
   input  logic [rv_core_pkg::xlen-1:0] b,
   output logic [rv_core_pkg::xlen-1:0] result,
   output logic                         cond
);
   import rv_core_pkg::*;

   logic [xlen-1:0] sum;
   logic [xlen-1:0] diff;
   logic [4:0]      shamt;
   logic            lt_s;
   logic            lt_u;
   logic            eq;

   assign sum   = a + b;
   assign diff  = a - b;
   assign shamt = b[4:0];
   assign lt_s  = $signed(a) < $signed(b);
   assign lt_u  = a < b;
   assign eq    = (a == b);

   always_comb begin
      result = sum;
      cond   = 1'b0;
      case (op)
         alu_sub:    result = diff;
         alu_sll:    result = a << shamt;
         alu_slt:    result = xlen'(lt_s);
         alu_sltu:   result = xlen'(lt_u);
         alu_xor:    result = a ^ b;
         alu_srl:    result = a >> shamt;
         alu_sra:    result = $unsigned($signed(a) >>> shamt);
         alu_or:     result = a | b;
         alu_and:    result = a & b;
         alu_pass_b: result = b;
         // Compares only drive cond
         alu_eq:     cond = eq;
         alu_ne:     cond = !eq;
         alu_lt:     cond = lt_s;
         alu_ge:     cond = !lt_s;
         alu_ltu:    cond = lt_u;
         alu_geu:    cond = !lt_u;
         default:    result = sum;
      endcase
   end

endmodule

/* design/rv_core.sv */
// ======================================
// RV32I multi-cycle core, top level
// Fetch, execute, optional load write-back
// One instruction in flight at a time
// ======================================
`timescale 1ns/1ps

module rv_core (
   input  logic                         clk,
   input  logic                         rst_n,
   // Instruction port
   output logic                         imem_req,
   output logic [rv_core_pkg::xlen-1:0] imem_addr,
   input  logic [rv_core_pkg::xlen-1:0] imem_rdata,
   // Data port
   output logic                         dmem_req,
   output logic                         dmem_write,
   output logic [rv_core_pkg::xlen-1:0] dmem_addr,
   output logic [rv_core_pkg::xlen-1:0] dmem_wdata,
   output logic [3:0]                   dmem_byte_en,
   input  logic [rv_core_pkg::xlen-1:0] dmem_rdata,
   output logic                         illegal_instruction
);
   import rv_core_pkg::*;

   core_state_e          state;
   logic [xlen-1:0]      pc;
   logic [reg_idx_w-1:0] load_rd;

   ctrl_t                ctrl;
   logic [reg_idx_w-1:0] rs1;
   logic [reg_idx_w-1:0] rs2;
   logic [reg_idx_w-1:0] rd;
   logic [xlen-1:0]      imm;
   logic                 illegal;

   logic [xlen-1:0]      rdata1;
   logic [xlen-1:0]      rdata2;
   logic [xlen-1:0]      alu_a;
   logic [xlen-1:0]      alu_b;
   logic [xlen-1:0]      alu_result;
   logic                 alu_cond;

   logic                 exec;
   logic                 rf_write;
   logic [reg_idx_w-1:0] rf_rd;
   logic [xlen-1:0]      wb_data;
   logic [xlen-1:0]      pc_plus4;
   logic [xlen-1:0]      pc_target;
   logic [xlen-1:0]      next_pc;

   dmem_req_if dmem_bus ();

   // ======================================
   // Sequencer
   // ======================================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= st_fetch;
         pc       <= reset_pc;
         imem_req <= 1'b0;
         load_rd  <= '0;
      end else begin
         case (state)
            st_fetch: begin
               // First cycle out of reset only raises the strobe
               if (imem_req) begin
                  imem_req <= 1'b0;
                  state    <= st_execute;
               end else begin
                  imem_req <= 1'b1;
               end
            end
            st_execute: begin
               pc      <= next_pc;
               load_rd <= rd;
               if (ctrl.mem_read) begin
                  state <= st_load_wb;
               end else begin
                  state    <= st_fetch;
                  imem_req <= 1'b1;
               end
            end
            default: begin
               state    <= st_fetch;
               imem_req <= 1'b1;
            end
         endcase
      end
   end

   assign imem_addr           = pc;
   assign exec                = (state == st_execute);
   assign illegal_instruction = exec && illegal;

   // ======================================
   // Datapath
   // ======================================
   rv_decoder decoder_inst (
      .instr   (imem_rdata),
      .ctrl    (ctrl),
      .rs1     (rs1),
      .rs2     (rs2),
      .rd      (rd),
      .imm     (imm),
      .illegal (illegal)
   );

   rv_regfile regfile_inst (
      .clk    (clk),
      .rst_n  (rst_n),
      .rs1    (rs1),
      .rs2    (rs2),
      .rd     (rf_rd),
      .write  (rf_write),
      .wdata  (wb_data),
      .rdata1 (rdata1),
      .rdata2 (rdata2)
   );

   assign alu_a = ctrl.porta_is_pc  ? pc  : rdata1;
   assign alu_b = ctrl.portb_is_imm ? imm : rdata2;

   rv_alu alu_inst (
      .op     (ctrl.alu_op),
      .a      (alu_a),
      .b      (alu_b),
      .result (alu_result),
      .cond   (alu_cond)
   );

   // Loads write back one cycle later, from load_wb
   assign rf_write = (exec && ctrl.reg_write && !ctrl.mem_read) || (state == st_load_wb);
   assign rf_rd    = (state == st_load_wb) ? load_rd : rd;

   always_comb begin
      if (state == st_load_wb) begin
         wb_data = dmem_bus.load_data;
      end else begin
         case (ctrl.wb_sel)
            wb_pc4:  wb_data = pc_plus4;
            default: wb_data = alu_result;
         endcase
      end
   end

   // JAL is the only pc4 write-back that is not JALR
   assign pc_plus4  = pc + 32'd4;
   assign pc_target = pc + imm;

   always_comb begin
      if (ctrl.is_jalr) begin
         next_pc = {alu_result[xlen-1:1], 1'b0};
      end else if ((ctrl.is_branch && alu_cond) || ctrl.wb_sel == wb_pc4) begin
         next_pc = pc_target;
      end else begin
         next_pc = pc_plus4;
      end
   end

   // ======================================
   // Data memory access
   // ======================================
   assign dmem_bus.valid       = exec && (ctrl.mem_read || ctrl.mem_write);
   assign dmem_bus.write       = ctrl.mem_write;
   assign dmem_bus.addr        = alu_result;
   assign dmem_bus.store_data  = rdata2;
   assign dmem_bus.size        = ctrl.mem_size;
   assign dmem_bus.is_unsigned = ctrl.mem_unsigned;

   rv_load_store load_store_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .req          (dmem_bus),
      .dmem_rdata   (dmem_rdata),
      .dmem_req     (dmem_req),
      .dmem_write   (dmem_write),
      .dmem_addr    (dmem_addr),
      .dmem_wdata   (dmem_wdata),
      .dmem_byte_en (dmem_byte_en)
   );

endmodule

/* design/rv_core_pkg.sv */
// ======================================
// RV32I core shared definitions
// Widths, instruction encodings, FSM states
// and the decoded control word
// ======================================
package rv_core_pkg;

   localparam int xlen      = 32;
   localparam int reg_count = 32;
   localparam int reg_idx_w = 5;

   localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

   // RV32I major opcodes, bits 6:0 of the instruction
   typedef enum logic [6:0] {
      op_lui    = 7'b0110111,
      op_auipc  = 7'b0010111,
      op_jal    = 7'b1101111,
      op_jalr   = 7'b1100111,
      op_branch = 7'b1100011,
      op_load   = 7'b0000011,
      op_store  = 7'b0100011,
      op_op_imm = 7'b0010011,
      op_op     = 7'b0110011
   } opcode_e;

   // Arithmetic operations first, branch compares after
   typedef enum logic [4:0] {
      alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
      alu_srl, alu_sra, alu_or, alu_and, alu_pass_b,
      alu_eq, alu_ne, alu_lt, alu_ge, alu_ltu, alu_geu
   } alu_op_e;

   // Matches funct3[1:0] of loads and stores
   typedef enum logic [1:0] {
      size_byte = 2'd0,
      size_half = 2'd1,
      size_word = 2'd2
   } mem_size_e;

   typedef enum logic [1:0] {
      st_fetch,
      st_execute,
      st_load_wb
   } core_state_e;

   typedef enum logic [1:0] {
      wb_alu,
      wb_pc4,
      wb_load
   } wb_sel_e;

   typedef struct packed {
      alu_op_e   alu_op;
      logic      porta_is_pc;
      logic      portb_is_imm;
      wb_sel_e   wb_sel;
      logic      reg_write;
      logic      mem_read;
      logic      mem_write;
      mem_size_e mem_size;
      logic      mem_unsigned;
      logic      is_branch;
      logic      is_jalr;
   } ctrl_t;

endpackage

/* design/rv_decoder.sv */
// ======================================
// RV32I instruction decoder
// Control word, immediate and illegal flag
// ======================================
`timescale 1ns/1ps

module rv_decoder (
   input  logic [rv_core_pkg::xlen-1:0]      instr,
   output rv_core_pkg::ctrl_t                ctrl,
   output logic [rv_core_pkg::reg_idx_w-1:0] rs1,
   output logic [rv_core_pkg::reg_idx_w-1:0] rs2,
   output logic [rv_core_pkg::reg_idx_w-1:0] rd,
   output logic [rv_core_pkg::xlen-1:0]      imm,
   output logic                              illegal
);
   import rv_core_pkg::*;

   opcode_e         opcode;
   logic [2:0]      funct3;
   logic [6:0]      funct7;
   logic            alt;
   logic [xlen-1:0] imm_i;
   logic [xlen-1:0] imm_s;
   logic [xlen-1:0] imm_b;
   logic [xlen-1:0] imm_u;
   logic [xlen-1:0] imm_j;

   assign opcode = opcode_e'(instr[6:0]);
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];
   assign alt    = instr[30];
   assign rs1    = instr[19:15];
   assign rs2    = instr[24:20];
   assign rd     = instr[11:7];

   // Immediate formats, all sign extended from bit 31
   assign imm_i = {{20{instr[31]}}, instr[31:20]};
   assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign imm_u = {instr[31:12], 12'b0};
   assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

   always_comb begin
      ctrl          = '0;
      ctrl.alu_op   = alu_add;
      ctrl.wb_sel   = wb_alu;
      ctrl.mem_size = size_word;
      imm           = imm_i;
      illegal       = 1'b0;

      case (opcode)
         op_lui: begin
            ctrl.alu_op       = alu_pass_b;
            ctrl.portb_is_imm = 1'b1;
            ctrl.reg_write    = 1'b1;
            imm               = imm_u;
         end
         op_auipc: begin
            ctrl.porta_is_pc  = 1'b1;
            ctrl.portb_is_imm = 1'b1;
            ctrl.reg_write    = 1'b1;
            imm               = imm_u;
         end
         op_jal: begin
            ctrl.wb_sel    = wb_pc4;
            ctrl.reg_write = 1'b1;
            imm            = imm_j;
         end
         op_jalr: begin
            ctrl.portb_is_imm = 1'b1;
            ctrl.wb_sel       = wb_pc4;
            ctrl.reg_write    = 1'b1;
            ctrl.is_jalr      = 1'b1;
            illegal           = (funct3 != 3'b000);
         end
         op_branch: begin
            ctrl.is_branch = 1'b1;
            imm            = imm_b;
            case (funct3)
               3'b000:  ctrl.alu_op = alu_eq;
               3'b001:  ctrl.alu_op = alu_ne;
               3'b100:  ctrl.alu_op = alu_lt;
               3'b101:  ctrl.alu_op = alu_ge;
               3'b110:  ctrl.alu_op = alu_ltu;
               3'b111:  ctrl.alu_op = alu_geu;
               default: illegal     = 1'b1;
            endcase
         end
         op_load: begin
            ctrl.portb_is_imm = 1'b1;
            ctrl.wb_sel       = wb_load;
            ctrl.reg_write    = 1'b1;
            ctrl.mem_read     = 1'b1;
            ctrl.mem_size     = mem_size_e'(funct3[1:0]);
            ctrl.mem_unsigned = funct3[2];
            // Only LB, LH, LW, LBU and LHU exist
            illegal = (funct3[1:0] == 2'b11) || (funct3[2] && funct3[1]);
         end
         op_store: begin
            ctrl.portb_is_imm = 1'b1;
            ctrl.mem_write    = 1'b1;
            ctrl.mem_size     = mem_size_e'(funct3[1:0]);
            imm               = imm_s;
            illegal           = funct3[2] || (funct3[1:0] == 2'b11);
         end
         op_op_imm, op_op: begin
            ctrl.portb_is_imm = (opcode == op_op_imm);
            ctrl.reg_write    = 1'b1;
            case (funct3)
               3'b000:  ctrl.alu_op = (opcode == op_op && alt) ? alu_sub : alu_add;
               3'b001:  ctrl.alu_op = alu_sll;
               3'b010:  ctrl.alu_op = alu_slt;
               3'b011:  ctrl.alu_op = alu_sltu;
               3'b100:  ctrl.alu_op = alu_xor;
               3'b101:  ctrl.alu_op = alt ? alu_sra : alu_srl;
               3'b110:  ctrl.alu_op = alu_or;
               default: ctrl.alu_op = alu_and;
            endcase
            // funct7 must be zero apart from SUB and SRA/SRAI
            if (opcode == op_op) begin
               illegal = !(funct7 == 7'b0 ||
                           (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
            end else if (funct3 == 3'b001) begin
               illegal = (funct7 != 7'b0);
            end else if (funct3 == 3'b101) begin
               illegal = (funct7 != 7'b0) && (funct7 != 7'b0100000);
            end
         end
         default: illegal = 1'b1;
      endcase

      // Illegal words fall through as a no-op
      if (illegal) begin
         ctrl.reg_write = 1'b0;
         ctrl.mem_read  = 1'b0;
         ctrl.mem_write = 1'b0;
         ctrl.is_branch = 1'b0;
         ctrl.is_jalr   = 1'b0;
         ctrl.wb_sel    = wb_alu;
      end
   end

endmodule

/* design/rv_load_store.sv */
// ======================================
// Load/store unit
// Lane placement of store data and byte enables,
// extraction and extension of load data
// ======================================
`timescale 1ns/1ps

module rv_load_store (
   input  logic                         clk,
   input  logic                         rst_n,
   dmem_req_if.unit                     req,
   input  logic [rv_core_pkg::xlen-1:0] dmem_rdata,
   output logic                         dmem_req,
   output logic                         dmem_write,
   output logic [rv_core_pkg::xlen-1:0] dmem_addr,
   output logic [rv_core_pkg::xlen-1:0] dmem_wdata,
   output logic [3:0]                   dmem_byte_en
);
   import rv_core_pkg::*;

   logic [1:0]      offset;
   logic [3:0]      lane_en;
   mem_size_e       rd_size;
   logic [1:0]      rd_offset;
   logic            rd_unsigned;
   logic [xlen-1:0] byte_word;
   logic [xlen-1:0] half_word;

   // ======================================
   // Request side
   // ======================================
   assign offset     = req.addr[1:0];
   assign dmem_req   = req.valid;
   assign dmem_write = req.valid && req.write;
   assign dmem_addr  = req.addr;

   always_comb begin
      case (req.size)
         size_byte: begin
            dmem_wdata = {4{req.store_data[7:0]}};
            lane_en    = 4'b0001 << offset;
         end
         size_half: begin
            dmem_wdata = {2{req.store_data[15:0]}};
            lane_en    = offset[1] ? 4'b1100 : 4'b0011;
         end
         default: begin
            dmem_wdata = req.store_data;
            lane_en    = 4'b1111;
         end
      endcase
   end

   assign dmem_byte_en = dmem_write ? lane_en : 4'b0000;

   // Read attributes held for the returning word
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_size     <= size_word;
         rd_offset   <= 2'b00;
         rd_unsigned <= 1'b0;
      end else if (req.valid && !req.write) begin
         rd_size     <= req.size;
         rd_offset   <= offset;
         rd_unsigned <= req.is_unsigned;
      end
   end

   // ======================================
   // Response side
   // ======================================
   assign byte_word = dmem_rdata >> {rd_offset, 3'b000};
   assign half_word = dmem_rdata >> {rd_offset[1], 4'b0000};

   always_comb begin
      case (rd_size)
         size_byte: begin
            req.load_data = {{24{!rd_unsigned && byte_word[7]}}, byte_word[7:0]};
         end
         size_half: begin
            req.load_data = {{16{!rd_unsigned && half_word[15]}}, half_word[15:0]};
         end
         default: req.load_data = dmem_rdata;
      endcase
   end

endmodule

/* design/rv_regfile.sv */
// ======================================
// Integer register file, 32 x 32 bits
// Two async read ports, one write port
// ======================================
`timescale 1ns/1ps

module rv_regfile (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic [rv_core_pkg::reg_idx_w-1:0] rs1,
   input  logic [rv_core_pkg::reg_idx_w-1:0] rs2,
   input  logic [rv_core_pkg::reg_idx_w-1:0] rd,
   input  logic                              write,
   input  logic [rv_core_pkg::xlen-1:0]      wdata,
   output logic [rv_core_pkg::xlen-1:0]      rdata1,
   output logic [rv_core_pkg::xlen-1:0]      rdata2
);
   import rv_core_pkg::*;

   logic [xlen-1:0] regs [reg_count];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < reg_count; i++) begin
            regs[i] <= '0;
         end
      end else if (write && rd != '0) begin
         regs[rd] <= wdata;
      end
   end

   // x0 reads as zero
   assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
   assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* sim.f */
design/rv_core_pkg.sv
design/dmem_req_if.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_load_store.sv
design/rv_core.sv
tests/tb_clock_gen.sv
tests/rv_core_assertions.sv
tests/rv_core_tb.sv

/* tests/rv_core_assertions.sv */
// ======================================
// Port protocol checks for the RV32I core
// ======================================
`timescale 1ns/1ps

module rv_core_assertions (
   input logic        clk,
   input logic        rst_n,
   input logic        imem_req,
   input logic        dmem_req,
   input logic        dmem_write,
   input logic [31:0] dmem_addr,
   input logic [3:0]  dmem_byte_en
);

   // Number of failed checks
   int unsigned fail_count = 0;

   // Only one port is active per cycle
   ports_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
      !(imem_req && dmem_req))
      else begin
         $error("imem_req and dmem_req high together");
         fail_count++;
      end

   enables_only_on_write: assert property (@(posedge clk) disable iff (!rst_n)
      !dmem_write |-> dmem_byte_en == 4'b0000)
      else begin
         $error("byte enables set without a write");
         fail_count++;
      end

   // Byte or half lane picked by the address, or the full word
   enables_in_lane: assert property (@(posedge clk) disable iff (!rst_n)
      dmem_write |-> dmem_byte_en == (4'b0001 << dmem_addr[1:0]) ||
                     dmem_byte_en == (dmem_addr[1] ? 4'b1100 : 4'b0011) ||
                     dmem_byte_en == 4'b1111)
      else begin
         $error("byte enables outside the addressed lane");
         fail_count++;
      end

   single_fetch_strobe: assert property (@(posedge clk) disable iff (!rst_n)
      imem_req |=> !imem_req)
      else begin
         $error("imem_req held for two cycles");
         fail_count++;
      end

endmodule

/* tests/rv_core_tb.sv */
// ======================================
// RV32I core testbench
// Program and expectations come from the data file
// and both memories answer one cycle after a strobe
// ======================================
`timescale 1ns/1ps

module rv_core_tb;

   localparam int mem_words   = 256;
   localparam int run_limit   = 4000;
   localparam int reset_limit = 100;

   logic        clk;
   logic        rst_n;
   logic        imem_req;
   logic [31:0] imem_addr;
   logic [31:0] imem_rdata;
   logic        dmem_req;
   logic        dmem_write;
   logic [31:0] dmem_addr;
   logic [31:0] dmem_wdata;
   logic [3:0]  dmem_byte_en;
   logic [31:0] dmem_rdata;
   logic        illegal_instruction;

   logic [31:0] imem [mem_words];
   logic [31:0] dmem [mem_words];

   // Expected events, consumed in order
   logic [31:0] store_addr_q [$];
   logic [31:0] store_data_q [$];
   logic [3:0]  store_be_q [$];
   logic [31:0] illegal_q [$];
   logic [31:0] end_addr;
   int          store_count;
   int          illegal_count;

   logic        fetch_hit;
   logic [31:0] fetch_addr;
   logic        load_hit;
   logic [31:0] load_addr;

   tb_clock_gen clock_gen_inst (
      .clk   (clk),
      .rst_n (rst_n)
   );

   rv_core rv_core_inst (
      .clk                 (clk),
      .rst_n               (rst_n),
      .imem_req            (imem_req),
      .imem_addr           (imem_addr),
      .imem_rdata          (imem_rdata),
      .dmem_req            (dmem_req),
      .dmem_write          (dmem_write),
      .dmem_addr           (dmem_addr),
      .dmem_wdata          (dmem_wdata),
      .dmem_byte_en        (dmem_byte_en),
      .dmem_rdata          (dmem_rdata),
      .illegal_instruction (illegal_instruction)
   );

   bind rv_core rv_core_assertions assertions_inst (.*);

   task automatic compare_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      if (expected !== actual) begin
         $display("Fail %s expected %08h actual %08h", name, expected, actual);
         $display("sim failed");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("sim failed");
      $fatal(1, "run aborted");
   endtask

   // ======================================
   // Data file loading
   // ======================================
   task automatic load_tests();
      int          fd;
      int          n;
      string       line;
      byte         tag;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      fd = $fopen("tests/rv_core_tests.dat", "r");
      if (fd == 0) begin
         abort_run("cannot open tests/rv_core_tests.dat");
      end
      // Unused words decode as illegal since the low bits are 00
      for (int i = 0; i < mem_words; i++) begin
         imem[i] = 32'hffff_0000 | (i << 2);
         dmem[i] = 32'h5a5a_0000 ^ (i << 2);
      end
      end_addr = '0;
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (line.len() < 3 || line[0] == "#") begin
            continue;
         end
         n = $sscanf(line, "%c %h %h %h", tag, a, b, c);
         case (tag)
            "P": begin
               imem[a[9:2]] = b;
               if (a > end_addr) end_addr = a;
            end
            "D": dmem[a[9:2]] = b;
            "S": begin
               store_addr_q.push_back(a);
               store_data_q.push_back(b);
               store_be_q.push_back(c[3:0]);
            end
            "I": illegal_q.push_back(a);
            default: abort_run("unknown tag in data file");
         endcase
      end
      $fclose(fd);
   endtask

   task automatic check_store();
      string name;
      if (store_addr_q.size() == 0) begin
         abort_run("a store appeared that the data file does not list");
      end
      name = $sformatf("store %0d", store_count);
      compare_value({name, " addr"}, store_addr_q.pop_front(), dmem_addr);
      compare_value({name, " data"}, store_data_q.pop_front(), dmem_wdata);
      compare_value({name, " byte_en"}, 32'(store_be_q.pop_front()), 32'(dmem_byte_en));
      for (int b = 0; b < 4; b++) begin
         if (dmem_byte_en[b]) begin
            dmem[dmem_addr[9:2]][8*b +: 8] = dmem_wdata[8*b +: 8];
         end
      end
      store_count++;
   endtask

   task automatic check_illegal();
      if (illegal_q.size() == 0) begin
         abort_run("illegal_instruction raised where none was expected");
      end
      compare_value($sformatf("illegal %0d", illegal_count), illegal_q.pop_front(), imem_addr);
      illegal_count++;
   endtask

   // ======================================
   // Memory models
   // ======================================
   always @(posedge clk) begin
      fetch_hit  = imem_req;
      fetch_addr = imem_addr;
      load_hit   = dmem_req && !dmem_write;
      load_addr  = dmem_addr;
      if (dmem_req && dmem_write) begin
         check_store();
      end
      if (illegal_instruction) begin
         check_illegal();
      end
      #1;
      if (fetch_hit) imem_rdata = imem[fetch_addr[9:2]];
      if (load_hit) dmem_rdata = dmem[load_addr[9:2]];
   end

   // Protocol checks of the bound assertion module
   always @(posedge clk) begin
      if (rv_core_inst.assertions_inst.fail_count != 0) begin
         abort_run("a port protocol assertion failed");
      end
   end

   initial begin
      int  cycles;
      bit  done;
      imem_rdata    = '0;
      dmem_rdata    = '0;
      store_count   = 0;
      illegal_count = 0;
      load_tests();

      cycles = 0;
      while (rst_n !== 1'b1 && cycles < reset_limit) begin
         @(posedge clk);
         cycles++;
      end
      if (rst_n !== 1'b1) begin
         abort_run("reset was never released");
      end

      // Run until the final self-loop is fetched
      done   = 1'b0;
      cycles = 0;
      while (!done && cycles < run_limit) begin
         @(posedge clk);
         cycles++;
         done = imem_req && (imem_addr == end_addr);
      end

      if (!done) begin
         abort_run("program did not reach its final loop in time");
      end else if (store_addr_q.size() != 0 || illegal_q.size() != 0) begin
         abort_run("some expected stores or illegal strobes never appeared");
      end else if (rv_core_inst.assertions_inst.fail_count != 0) begin
         abort_run("a port protocol assertion failed");
      end else begin
         $display("sim passed");
         $finish;
      end
   end

endmodule

/* tests/rv_core_tests.dat */
# P addr word | D addr word | S addr wdata byte_en | I fetch addr
# ALU: x1=5 x2=-3, add sub slt sltu srai lui auipc
P 000 00500093
P 004 FFD00113
P 008 002081B3
P 00C 40208233
P 010 001122B3
P 014 00113333
P 018 40115393
P 01C 12345437
P 020 00001497
P 024 10302023
P 028 10402223
P 02C 10502423
P 030 10602623
P 034 10702823
P 038 10802A23
P 03C 10902C23
S 100 00000002 F
S 104 00000008 F
S 108 00000001 F
S 10C 00000000 F
S 110 FFFFFFFE F
S 114 12345000 F
S 118 00001020 F
# Branches and jumps, stores to 11C are skipped
P 040 00108463
P 044 10102E23
P 048 00109463
P 04C 0080056F
P 050 10102E23
P 054 12A02023
P 058 061005E7
P 05C 10102E23
P 060 12B02223
S 120 00000050 F
S 124 0000005C F
# SB and SH lanes with x12=A1B2C3D4
P 064 A1B2C637
P 068 3D460613
P 06C 12C008A3
P 070 12C009A3
P 074 12C01B23
P 078 12C01A23
S 131 D4D4D4D4 2
S 133 D4D4D4D4 8
S 136 C3D4C3D4 C
S 134 C3D4C3D4 3
# Loads LB LBU LH LHU LW, stored back
D 200 80F17F85
P 07C 20000683
P 080 20304703
P 084 20201783
P 088 20005803
P 08C 20002883
P 090 14D02023
P 094 14E02223
P 098 14F02423
P 09C 15002623
P 0A0 15102823
S 140 FFFFFF85 F
S 144 00000080 F
S 148 FFFF80F1 F
S 14C 00007F85 F
S 150 80F17F85 F
# x0 write discarded, illegal word, then self loop
P 0A4 00700013
P 0A8 14002A23
P 0AC FFFFFFFF
P 0B0 14102C23
P 0B4 0000006F
S 154 00000000 F
S 158 00000005 F
I 0AC

/* tests/tb_clock_gen.sv */
// ======================================
// Testbench clock and reset source
// 4 ns clock, reset low for 16 cycles
// ======================================
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      rst_n = 1'b0;
      repeat (16) @(posedge clk);
      #1 rst_n = 1'b1;
   end

endmodule
